// File: Makefile
# Verilator build and run for the edge detector testbench.

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_edge_detect
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the simulation output holds the pass message.
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
hdl/edge_pkg.sv
hdl/line_buffer.sv
hdl/window_3x3.sv
hdl/sobel_gradient.sv
hdl/gradient_magnitude.sv
hdl/edge_detect_top.sv
testbench/tb_edge_detect.sv

// File: hdl/edge_detect_top.sv
// ======================================
// Streaming 3x3 Sobel edge detector.
// One output pixel per input pixel, with
// valid/ready handshakes on both sides.
// ======================================
`timescale 1ns/10ps

module edge_detect_top (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_valid,
    output logic             o_ready,
    input  edge_pkg::pixel_t i_pixel,
    input  logic             i_sof,
    input  edge_pkg::pixel_t i_threshold,
    output logic             o_valid,
    input  logic             i_ready,
    output edge_pkg::pixel_t o_magnitude,
    output logic             o_edge,
    output logic             o_sof
);
    import edge_pkg::*;

    logic   advance;

    logic   lb_valid;
    pixel_t lb_top;
    pixel_t lb_mid;
    pixel_t lb_bot;
    logic   lb_border;
    logic   lb_sof;

    logic   win_valid;
    pixel_t w11;
    pixel_t w12;
    pixel_t w13;
    pixel_t w21;
    pixel_t w22;
    pixel_t w23;
    pixel_t w31;
    pixel_t w32;
    pixel_t w33;
    logic   win_border;
    logic   win_sof;

    logic   gx_valid;
    logic   gy_valid;
    grad_t  grad_x;
    grad_t  grad_y;

    // The whole pipeline moves together whenever the output slot is free.
    assign advance = !o_valid || i_ready;
    assign o_ready = advance;

    line_buffer u_line_buffer (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_advance (advance),
        .i_valid   (i_valid),
        .i_pixel   (i_pixel),
        .i_sof     (i_sof),
        .o_valid   (lb_valid),
        .o_top     (lb_top),
        .o_mid     (lb_mid),
        .o_bot     (lb_bot),
        .o_border  (lb_border),
        .o_sof     (lb_sof)
    );

    window_3x3 u_window (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_advance (advance),
        .i_valid   (lb_valid),
        .i_top     (lb_top),
        .i_mid     (lb_mid),
        .i_bot     (lb_bot),
        .i_border  (lb_border),
        .i_sof     (lb_sof),
        .o_valid   (win_valid),
        .o_w11     (w11),
        .o_w12     (w12),
        .o_w13     (w13),
        .o_w21     (w21),
        .o_w22     (w22),
        .o_w23     (w23),
        .o_w31     (w31),
        .o_w32     (w32),
        .o_w33     (w33),
        .o_border  (win_border),
        .o_sof     (win_sof)
    );

    sobel_gradient #(.VERTICAL(1'b0)) u_grad_x (
        .clk (clk), .i_reset (i_reset), .i_advance (advance), .i_valid (win_valid),
        .i_w11 (w11), .i_w12 (w12), .i_w13 (w13),
        .i_w21 (w21), .i_w22 (w22), .i_w23 (w23),
        .i_w31 (w31), .i_w32 (w32), .i_w33 (w33),
        .o_valid (gx_valid),
        .o_grad  (grad_x)
    );

    sobel_gradient #(.VERTICAL(1'b1)) u_grad_y (
        .clk (clk), .i_reset (i_reset), .i_advance (advance), .i_valid (win_valid),
        .i_w11 (w11), .i_w12 (w12), .i_w13 (w13),
        .i_w21 (w21), .i_w22 (w22), .i_w23 (w23),
        .i_w31 (w31), .i_w32 (w32), .i_w33 (w33),
        .o_valid (gy_valid),
        .o_grad  (grad_y)
    );

    gradient_magnitude u_magnitude (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_advance   (advance),
        .i_valid     (gx_valid && gy_valid),
        .i_grad_x    (grad_x),
        .i_grad_y    (grad_y),
        .i_border    (win_border),
        .i_sof       (win_sof),
        .i_threshold (i_threshold),
        .o_valid     (o_valid),
        .o_magnitude (o_magnitude),
        .o_edge      (o_edge),
        .o_sof       (o_sof)
    );

endmodule : edge_detect_top

// File: hdl/edge_pkg.sv
// ======================================
// Edge detector shared definitions.
// Frame constants and the pixel, gradient
// and coordinate types of the pipeline.
// ======================================
package edge_pkg;

    // Pixels per row of the incoming frame.
    localparam int LINE_WIDTH = 32;

    // Cycles from an accepted pixel to its result when nothing stalls.
    localparam int PIPE_LATENCY = 4;

    localparam int COL_BITS  = $clog2(LINE_WIDTH);
    localparam int GRAD_BITS = 11;

    // Grayscale pixel, also used for the magnitude and the threshold.
    typedef logic [7:0] pixel_t;

    // Signed Sobel gradient, wide enough for +/-1020.
    typedef logic signed [GRAD_BITS-1:0] grad_t;

    typedef logic [COL_BITS-1:0] col_t;

    // Row count saturates at 2, since only the first two rows are special.
    typedef logic [1:0] row_t;

    localparam col_t   LAST_COL  = col_t'(LINE_WIDTH - 1);
    localparam row_t   ROW_FULL  = 2'd2;
    localparam pixel_t PIXEL_MAX = 8'hff;

endpackage : edge_pkg

// File: hdl/gradient_magnitude.sv
// ======================================
// Gradient magnitude and edge flag.
// Sums absolute gradients, saturates,
// blanks the border and thresholds.
// ======================================
`timescale 1ns/10ps

module gradient_magnitude (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_advance,
    input  logic             i_valid,
    input  edge_pkg::grad_t  i_grad_x,
    input  edge_pkg::grad_t  i_grad_y,
    input  logic             i_border,
    input  logic             i_sof,
    input  edge_pkg::pixel_t i_threshold,
    output logic             o_valid,
    output edge_pkg::pixel_t o_magnitude,
    output logic             o_edge,
    output logic             o_sof
);
    import edge_pkg::*;

    function automatic logic [GRAD_BITS-2:0] abs_grad(input grad_t g);
        grad_t pos;
        pos = g[GRAD_BITS-1] ? -g : g;
        return pos[GRAD_BITS-2:0];
    endfunction

    logic                 border_q;
    logic                 sof_q;
    logic [GRAD_BITS-1:0] sum_abs;
    pixel_t               mag_d;

    // The flags come from the window stage and need one cycle to line up
    // with the gradients.
    always_ff @(posedge clk) begin
        if (i_advance) begin
            border_q <= i_border;
        end
    end

    assign sum_abs = {1'b0, abs_grad(i_grad_x)} + {1'b0, abs_grad(i_grad_y)};

    always_comb begin
        if (border_q) begin
            mag_d = '0;
        end else if (|sum_abs[GRAD_BITS-1:8]) begin
            mag_d = PIXEL_MAX;
        end else begin
            mag_d = sum_abs[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sof_q   <= 1'b0;
            o_valid <= 1'b0;
            o_sof   <= 1'b0;
        end else if (i_advance) begin
            sof_q   <= i_sof;
            o_valid <= i_valid;
            o_sof   <= i_valid && sof_q;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && i_valid) begin
            o_magnitude <= mag_d;
            o_edge      <= mag_d > i_threshold;
        end
    end

    // The first pixel of a frame is a corner of the border and is blanked.
    a_sof_blanked : assert property (
        @(posedge clk) disable iff (i_reset)
        (o_valid && o_sof) |-> (o_magnitude == '0)
    );

endmodule : gradient_magnitude

// File: hdl/line_buffer.sv
// ======================================
// Two-row line buffer.
// Delivers a vertical three-pixel column,
// a border flag and the frame start flag.
// ======================================
`timescale 1ns/10ps

module line_buffer (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_advance,
    input  logic             i_valid,
    input  edge_pkg::pixel_t i_pixel,
    input  logic             i_sof,
    output logic             o_valid,
    output edge_pkg::pixel_t o_top,
    output edge_pkg::pixel_t o_mid,
    output edge_pkg::pixel_t o_bot,
    output logic             o_border,
    output logic             o_sof
);
    import edge_pkg::*;

    pixel_t mem_older [LINE_WIDTH];
    pixel_t mem_newer [LINE_WIDTH];

    col_t   col_cnt;
    row_t   row_cnt;
    col_t   cur_col;
    row_t   cur_row;
    pixel_t rd_older;
    pixel_t rd_newer;
    logic   accept;

    assign accept = i_advance && i_valid;

    // A start-of-frame pixel is always column 0 of row 0.
    assign cur_col = i_sof ? '0 : col_cnt;
    assign cur_row = i_sof ? '0 : row_cnt;

    assign rd_older = mem_older[cur_col];
    assign rd_newer = mem_newer[cur_col];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            col_cnt <= '0;
            row_cnt <= '0;
            o_valid <= 1'b0;
            o_sof   <= 1'b0;
        end else if (i_advance) begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_sof <= i_sof;
                if (cur_col == LAST_COL) begin
                    col_cnt <= '0;
                    if (cur_row != ROW_FULL) begin
                        row_cnt <= cur_row + 2'd1;
                    end else begin
                        row_cnt <= cur_row;
                    end
                end else begin
                    col_cnt <= cur_col + col_t'(1);
                    row_cnt <= cur_row;
                end
            end
        end
    end

    // The newer row moves down into the older one as it is overwritten.
    always_ff @(posedge clk) begin
        if (accept) begin
            mem_newer[cur_col] <= i_pixel;
            mem_older[cur_col] <= rd_newer;
            o_top              <= rd_older;
            o_mid              <= rd_newer;
            o_bot              <= i_pixel;
            o_border           <= (cur_col < col_t'(2)) || (cur_row < ROW_FULL);
        end
    end

    a_row_saturated : assert property (
        @(posedge clk) disable iff (i_reset)
        row_cnt <= ROW_FULL
    );

endmodule : line_buffer

// File: hdl/sobel_gradient.sv
// ======================================
// Sobel gradient, one orientation.
// VERTICAL 0 gives Gx, VERTICAL 1 gives Gy.
// ======================================
`timescale 1ns/10ps

module sobel_gradient #(
    parameter bit VERTICAL = 1'b0
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_advance,
    input  logic             i_valid,
    input  edge_pkg::pixel_t i_w11,
    input  edge_pkg::pixel_t i_w12,
    input  edge_pkg::pixel_t i_w13,
    input  edge_pkg::pixel_t i_w21,
    input  edge_pkg::pixel_t i_w22,
    input  edge_pkg::pixel_t i_w23,
    input  edge_pkg::pixel_t i_w31,
    input  edge_pkg::pixel_t i_w32,
    input  edge_pkg::pixel_t i_w33,
    output logic             o_valid,
    output edge_pkg::grad_t  o_grad
);
    import edge_pkg::*;

    // Weighted 1-2-1 sum of three pixels, at most 1020.
    function automatic logic [GRAD_BITS-2:0] weighted(input pixel_t a, input pixel_t b,
                                                      input pixel_t c);
        return {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    logic [GRAD_BITS-2:0] pos_sum;
    logic [GRAD_BITS-2:0] neg_sum;
    grad_t                grad_d;

    if (VERTICAL) begin : g_vertical
        assign pos_sum = weighted(i_w31, i_w32, i_w33);
        assign neg_sum = weighted(i_w11, i_w12, i_w13);
    end else begin : g_horizontal
        assign pos_sum = weighted(i_w13, i_w23, i_w33);
        assign neg_sum = weighted(i_w11, i_w21, i_w31);
    end

    // The centre pixel has zero weight in both orientations
    assign grad_d = $signed({1'b0, pos_sum}) - $signed({1'b0, neg_sum});

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (i_advance) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && i_valid) begin
            o_grad <= grad_d;
        end
    end

endmodule : sobel_gradient

// File: hdl/window_3x3.sv
// ======================================
// 3x3 window register.
// Shifts columns in from the right and
// keeps the flags aligned with them.
// ======================================
`timescale 1ns/10ps

module window_3x3 (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_advance,
    input  logic             i_valid,
    input  edge_pkg::pixel_t i_top,
    input  edge_pkg::pixel_t i_mid,
    input  edge_pkg::pixel_t i_bot,
    input  logic             i_border,
    input  logic             i_sof,
    output logic             o_valid,
    output edge_pkg::pixel_t o_w11,
    output edge_pkg::pixel_t o_w12,
    output edge_pkg::pixel_t o_w13,
    output edge_pkg::pixel_t o_w21,
    output edge_pkg::pixel_t o_w22,
    output edge_pkg::pixel_t o_w23,
    output edge_pkg::pixel_t o_w31,
    output edge_pkg::pixel_t o_w32,
    output edge_pkg::pixel_t o_w33,
    output logic             o_border,
    output logic             o_sof
);

    logic shift;

    // Bubbles must not enter the window, so it only moves on real pixels.
    assign shift = i_advance && i_valid;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_sof   <= 1'b0;
        end else if (i_advance) begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_sof <= i_sof;
            end
        end
    end

    // Column 3 is the newest, so w33 is the pixel that was just accepted.
    always_ff @(posedge clk) begin
        if (shift) begin
            {o_w11, o_w12, o_w13} <= {o_w12, o_w13, i_top};
            {o_w21, o_w22, o_w23} <= {o_w22, o_w23, i_mid};
            {o_w31, o_w32, o_w33} <= {o_w32, o_w33, i_bot};
            o_border              <= i_border;
        end
    end

    // The first pixel of a frame sits in column 0 of row 0.
    a_sof_is_border : assert property (
        @(posedge clk) disable iff (i_reset)
        (o_valid && o_sof) |-> o_border
    );

endmodule : window_3x3

// File: testbench/tb_edge_detect.sv
// ========================================
// Testbench for the streaming edge detector.
// Sends directed frames and checks every
// output pixel against a Sobel model.
// ========================================
`timescale 1ns/10ps

module tb_edge_detect;
    import edge_pkg::*;

    localparam int FRAME_ROWS   = 6;
    localparam int FRAME_PIXELS = LINE_WIDTH * FRAME_ROWS;
    localparam int TIMEOUT      = 1000;

    logic   clk = 1'b0;
    logic   i_reset;
    logic   i_valid;
    logic   o_ready;
    pixel_t i_pixel;
    logic   i_sof;
    pixel_t i_threshold;
    logic   o_valid;
    logic   i_ready;
    pixel_t o_magnitude;
    logic   o_edge;
    logic   o_sof;

    pixel_t      frame [FRAME_PIXELS];
    int          gap_len [FRAME_PIXELS];
    bit          ready_pat [FRAME_PIXELS];
    logic [15:0] lfsr_state = 16'd77;
    int          cycle_count = 0;
    int          first_accept = 0;
    int          first_output = 0;
    bit          collect_done = 1'b0;
    int          check_total = 0;
    int          error_count = 0;

    edge_detect_top dut (
        .clk         (clk),         .i_reset     (i_reset),
        .i_valid     (i_valid),     .o_ready     (o_ready),
        .i_pixel     (i_pixel),     .i_sof       (i_sof),
        .i_threshold (i_threshold), .o_valid     (o_valid),
        .i_ready     (i_ready),     .o_magnitude (o_magnitude),
        .o_edge      (o_edge),      .o_sof       (o_sof)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1.
    function automatic bit lfsr_bit();
        bit out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[6:0], lfsr_bit()};
        end
        return value;
    endfunction

    function automatic int pixel_at(input int row, input int col);
        return int'(frame[row * LINE_WIDTH + col]);
    endfunction

    // Output k is the window whose bottom-right corner is input pixel k.
    function automatic pixel_t expected_magnitude(input int k);
        int r;
        int c;
        int gx;
        int gy;
        int sum;
        r = k / LINE_WIDTH;
        c = k % LINE_WIDTH;
        if (r < 2 || c < 2) begin
            return '0;
        end
        gx = pixel_at(r - 2, c) + 2 * pixel_at(r - 1, c) + pixel_at(r, c)
           - pixel_at(r - 2, c - 2) - 2 * pixel_at(r - 1, c - 2) - pixel_at(r, c - 2);
        gy = pixel_at(r, c - 2) + 2 * pixel_at(r, c - 1) + pixel_at(r, c)
           - pixel_at(r - 2, c - 2) - 2 * pixel_at(r - 2, c - 1) - pixel_at(r - 2, c);
        if (gx < 0) begin
            gx = -gx;
        end
        if (gy < 0) begin
            gy = -gy;
        end
        sum = gx + gy;
        if (sum > 255) begin
            sum = 255;
        end
        return pixel_t'(sum);
    endfunction

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_total++;
        if (got != exp) begin
            error_count++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        error_count++;
        $display("Timed out at %0t while waiting for %s.", $time, what);
        finish_run();
    endtask

    task automatic set_threshold(input pixel_t value);
        @(posedge clk);
        #1;
        i_threshold = value;
    endtask

    // Kind 0 is flat, kind 1 a vertical step, kind 2 random.
    task automatic fill_frame(input int kind);
        for (int k = 0; k < FRAME_PIXELS; k++) begin
            if (kind == 0) begin
                frame[k] = 8'd100;
            end else if (kind == 1) begin
                frame[k] = ((k % LINE_WIDTH) < LINE_WIDTH / 2) ? 8'd0 : 8'd200;
            end else begin
                frame[k] = pixel_t'(rand_bits(8));
            end
        end
    endtask

    task automatic send_frame();
        int waited;
        bit accepted;
        for (int k = 0; k < FRAME_PIXELS; k++) begin
            repeat (gap_len[k]) begin
                i_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            i_valid  = 1'b1;
            i_pixel  = frame[k];
            i_sof    = (k == 0);
            accepted = 1'b0;
            waited   = 0;
            while (!accepted) begin
                @(negedge clk);
                if (o_ready) begin
                    accepted = 1'b1;
                    if (k == 0) begin
                        first_accept = cycle_count;
                    end
                end else begin
                    waited++;
                    if (waited > TIMEOUT) begin
                        fail_timeout("the DUT to accept a pixel");
                    end
                end
                @(posedge clk);
                #1;
            end
        end
        i_valid = 1'b0;
        i_sof   = 1'b0;
    endtask

    // A transfer seen at the falling edge completes at the next rising edge.
    task automatic collect_frame();
        int     got;
        int     idle;
        bit     stalled;
        pixel_t exp_mag;
        pixel_t held_mag;
        logic   held_edge;
        logic   held_sof;
        got          = 0;
        idle         = 0;
        stalled      = 1'b0;
        first_output = -1;
        while (got < FRAME_PIXELS) begin
            @(negedge clk);
            if (stalled) begin
                check_flag("o_valid (stalled)", o_valid, 1'b1);
                check_pixel("o_magnitude (stalled)", o_magnitude, held_mag);
                check_flag("o_edge (stalled)", o_edge, held_edge);
                check_flag("o_sof (stalled)", o_sof, held_sof);
            end
            if (o_valid && !i_ready) begin
                check_flag("o_ready (output held)", o_ready, 1'b0);
            end
            if (o_valid && first_output < 0) begin
                first_output = cycle_count;
            end
            stalled   = o_valid && !i_ready;
            held_mag  = o_magnitude;
            held_edge = o_edge;
            held_sof  = o_sof;
            if (o_valid && i_ready) begin
                exp_mag = expected_magnitude(got);
                check_pixel($sformatf("o_magnitude[%0d]", got), o_magnitude, exp_mag);
                check_flag($sformatf("o_edge[%0d]", got), o_edge, exp_mag > i_threshold);
                check_flag($sformatf("o_sof[%0d]", got), o_sof, got == 0);
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    fail_timeout("an output pixel");
                end
            end
        end
    endtask

    task automatic drive_ready(input bit stall_mode);
        int idx;
        idx = 0;
        while (!collect_done && idx < 8 * TIMEOUT) begin
            @(posedge clk);
            #1;
            i_ready = stall_mode ? ready_pat[idx % FRAME_PIXELS] : 1'b1;
            idx++;
        end
        i_ready = 1'b1;
    endtask

    task automatic run_frame(input bit stall_mode, input bit check_latency);
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            gap_len[i]   = 0;
            ready_pat[i] = 1'b1;
            if (stall_mode) begin
                gap_len[i]   = (rand_bits(2) == 8'd0) ? int'(rand_bits(2)) : 0;
                ready_pat[i] = (rand_bits(2) != 8'd0);
            end
        end
        collect_done = 1'b0;
        @(posedge clk);
        #1;
        fork
            send_frame();
            begin
                collect_frame();
                collect_done = 1'b1;
            end
            drive_ready(stall_mode);
        join
        // Once drained, nothing beyond one output per input may appear.
        repeat (PIPE_LATENCY + 2) @(negedge clk);
        check_flag("o_valid after frame", o_valid, 1'b0);
        if (check_latency) begin
            check_count("first output latency", first_output - first_accept, PIPE_LATENCY);
        end
    endtask

    task automatic flat_frame();
        set_threshold(8'd10);
        fill_frame(0);
        run_frame(1'b0, 1'b0);
    endtask

    task automatic vertical_step();
        set_threshold(8'd100);
        fill_frame(1);
        run_frame(1'b0, 1'b0);
    endtask

    task automatic random_frame();
        set_threshold(8'd60);
        fill_frame(2);
        run_frame(1'b0, 1'b1);
    endtask

    task automatic random_stalls();
        set_threshold(8'd60);
        fill_frame(2);
        run_frame(1'b1, 1'b0);
    endtask

    // The second threshold equals one real magnitude, so equality is exercised.
    task automatic two_thresholds();
        fill_frame(2);
        set_threshold(8'd40);
        run_frame(1'b0, 1'b0);
        set_threshold(expected_magnitude(3 * LINE_WIDTH + 7));
        run_frame(1'b0, 1'b0);
    endtask

    task automatic reset_mid_frame();
        set_threshold(8'd60);
        fill_frame(2);
        for (int k = 0; k < 40; k++) begin
            i_valid = 1'b1;
            i_pixel = frame[k];
            i_sof   = (k == 0);
            @(posedge clk);
            #1;
        end
        i_valid = 1'b0;
        i_sof   = 1'b0;
        i_reset = 1'b1;
        @(negedge clk);
        check_flag("o_valid before reset", o_valid, 1'b1);
        repeat (3) @(posedge clk);
        #1;
        i_reset = 1'b0;
        @(negedge clk);
        check_flag("o_valid after reset", o_valid, 1'b0);
        fill_frame(2);
        run_frame(1'b0, 1'b0);
    endtask

    initial begin
        i_reset     = 1'b1;
        i_valid     = 1'b0;
        i_pixel     = '0;
        i_sof       = 1'b0;
        i_threshold = '0;
        i_ready     = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        i_reset = 1'b0;
        flat_frame();
        vertical_step();
        random_frame();
        random_stalls();
        two_thresholds();
        reset_mid_frame();
        finish_run();
    end

endmodule : tb_edge_detect
